//--- mem_stage.f
+incdir+include
rtl/mem_stage_pkg.sv
rtl/mem_align_check.sv
rtl/mem_exc_regs.sv
rtl/data_ram.sv
rtl/load_extend.sv
rtl/mem_stage.sv
dv/mem_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory stage testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module mem_stage_tb -f mem_stage.f \
    -o mem_stage_sim > build.log 2>&1 &&
./obj_dir/mem_stage_sim > sim.log 2>&1 ||
{ echo "Build or run failed, see build.log and sim.log"; exit 1; }

grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

//--- dv/mem_stage_tb.sv
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module mem_stage_tb;
    typedef logic [3:0][7:0] word_bytes_t;

    // Reset plus the six test sections, then doubled
    localparam int CYCLE_LIMIT = 2 * (10 + 9 + 46 + 40 + 24 + 9 + 306);

    logic                    clk;
    logic                    reset;
    mem_stage_pkg::mem_req_t req;
    mem_stage_pkg::mem_rsp_t rsp;
    mem_stage_pkg::cfg_req_t cfg;
    logic [31:0]             cfg_rdata;

    word_bytes_t ref_mem [`MEM_WORDS]; // Reference memory, little-endian lanes
    logic        check_en_m;
    logic [4:0]  last_code_m;
    logic [31:0] bad_vaddr_m;
    logic [31:0] exc_pc_m;
    logic [31:0] exc_count_m;
    logic [31:0] pc_next;
    logic [31:0] fault_total;
    logic [31:0] rand_start;
    logic [31:0] r_ctl;
    logic [31:0] r_addr;
    logic [2:0]  pick;
    int          cycles = 0;
    int          test_num;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    integer      seed;

    mem_stage mem_stage_i (.clk(clk), .reset(reset), .req(req), .rsp(rsp), .cfg(cfg),
                           .cfg_rdata(cfg_rdata));

    function automatic logic is_misaligned(mem_stage_pkg::mem_access_e acc, logic [1:0] off);
        if (acc == mem_stage_pkg::ACC_W)
            return off != 2'b00;
        if (acc == mem_stage_pkg::ACC_H || acc == mem_stage_pkg::ACC_HU)
            return off[0];
        return 1'b0;
    endfunction

    // Byte offset actually used once alignment is ignored
    function automatic logic [1:0] effective_offset(mem_stage_pkg::mem_access_e acc,
                                                    logic [1:0] off);
        if (acc == mem_stage_pkg::ACC_W)
            return 2'b00;
        if (acc == mem_stage_pkg::ACC_H || acc == mem_stage_pkg::ACC_HU)
            return {off[1], 1'b0};
        return off;
    endfunction

    function automatic logic [31:0] expected_load(mem_stage_pkg::mem_access_e acc,
                                                  logic [1:0] off, word_bytes_t m,
                                                  word_bytes_t rt);
        word_bytes_t r;
        logic [15:0] half;
        logic [7:0]  bt;
        int          b;
        int          src;
        r    = rt;
        half = {m[off + 2'd1], m[off]};
        bt   = m[off];
        b    = int'(off);
        case (acc)
            mem_stage_pkg::ACC_H:  return {{16{half[15]}}, half};
            mem_stage_pkg::ACC_HU: return {16'd0, half};
            mem_stage_pkg::ACC_B:  return {{24{bt[7]}}, bt};
            mem_stage_pkg::ACC_BU: return {24'd0, bt};
            mem_stage_pkg::ACC_WL:
            begin
                for (int k = 3 - b; k < 4; k++)
                begin
                    src = k - (3 - b);
                    r[k[1:0]] = m[src[1:0]];
                end
                return r;
            end
            mem_stage_pkg::ACC_WR:
            begin
                for (int k = 0; k <= 3 - b; k++)
                begin
                    src = k + b;
                    r[k[1:0]] = m[src[1:0]];
                end
                return r;
            end
            default: return m;
        endcase
    endfunction

    function automatic logic [31:0] merged_store(mem_stage_pkg::mem_access_e acc,
                                                 logic [1:0] off, word_bytes_t m,
                                                 word_bytes_t wd);
        word_bytes_t w;
        int          b;
        int          src;
        w = m;
        b = int'(off);
        case (acc)
            mem_stage_pkg::ACC_W:
                w = wd;
            mem_stage_pkg::ACC_H,
            mem_stage_pkg::ACC_HU:
            begin
                w[off]         = wd[0];
                w[off + 2'd1]  = wd[1];
            end
            mem_stage_pkg::ACC_WL:
            begin
                for (int k = 0; k <= b; k++)
                begin
                    src = k + 3 - b; // Top wdata bytes
                    w[k[1:0]] = wd[src[1:0]];
                end
            end
            mem_stage_pkg::ACC_WR:
            begin
                for (int k = b; k < 4; k++)
                begin
                    src = k - b;
                    w[k[1:0]] = wd[src[1:0]];
                end
            end
            default:
                w[off] = wd[0];
        endcase
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        total_checks++;
        assert (got == exp)
        else
        begin
            $display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
            test_errors++;
            total_errors++;
        end
    endtask

    task automatic run_access(input logic we, input mem_stage_pkg::mem_access_e acc,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] rt_old);
        logic [`MEM_INDEX_BITS-1:0] idx;
        logic [1:0]                 off;
        logic                       fault;
        logic [4:0]                 code;
        idx   = addr[`MEM_ADDR_BITS-1:2];
        off   = effective_offset(acc, addr[1:0]);
        fault = check_en_m && is_misaligned(acc, addr[1:0]);
        code  = !fault ? 5'd0 : (we ? `EXC_ADES : `EXC_ADEL);
        @(negedge clk);
        req.valid  = 1'b1;
        req.we     = we;
        req.access = acc;
        req.addr   = addr;
        req.wdata  = wdata;
        req.rt_old = rt_old;
        req.pc     = pc_next;
        cfg.we     = 1'b0;
        #20;
        check_value("rsp.exc", {31'd0, rsp.exc}, {31'd0, fault});
        check_value("rsp.exc_code", {27'd0, rsp.exc_code}, {27'd0, code});
        if (!we && !fault)
            check_value("rsp.rdata", rsp.rdata, expected_load(acc, off, ref_mem[idx], rt_old));
        if (fault)
        begin
            last_code_m = code;
            bad_vaddr_m = addr;
            exc_pc_m    = pc_next;
            if (exc_count_m != '1)
                exc_count_m = exc_count_m + 32'd1;
            fault_total = fault_total + 32'd1;
        end
        else if (we)
        begin
            ref_mem[idx] = merged_store(acc, off, ref_mem[idx], wdata);
        end
        pc_next = pc_next + 32'd4;
    endtask

    task automatic read_cfg(input logic [1:0] a, input logic [31:0] exp, input string name);
        @(negedge clk);
        req.valid = 1'b0;
        cfg.we    = 1'b0;
        cfg.addr  = a;
        #20;
        check_value(name, cfg_rdata, exp);
        check_value("rsp.exc while idle", {31'd0, rsp.exc}, 32'd0);
    endtask

    task automatic write_cfg(input logic [1:0] a, input logic [31:0] data);
        @(negedge clk);
        req.valid = 1'b0;
        cfg.we    = 1'b1;
        cfg.addr  = a;
        cfg.wdata = data;
        if (a == 2'd0)
            check_en_m = data[0];
        if (a == 2'd3)
            exc_count_m = '0;
    endtask

    task automatic check_regs();
        read_cfg(2'd0, {25'd0, last_code_m, 1'b0, check_en_m}, "control");
        read_cfg(2'd1, bad_vaddr_m, "bad_vaddr");
        read_cfg(2'd2, exc_pc_m, "exc_pc");
        read_cfg(2'd3, exc_count_m, "exc_count");
    endtask

    // LW, then every legal half and byte offset of one word
    task automatic check_all_loads(input logic [31:0] base);
        run_access(1'b0, mem_stage_pkg::ACC_W, base, '0, 32'h5a5a_a5a5);
        for (int k = 0; k < 4; k++)
        begin
            if (k[0] == 1'b0)
            begin
                run_access(1'b0, mem_stage_pkg::ACC_H, base + k, '0, '0);
                run_access(1'b0, mem_stage_pkg::ACC_HU, base + k, '0, '0);
            end
            run_access(1'b0, mem_stage_pkg::ACC_B, base + k, '0, '0);
            run_access(1'b0, mem_stage_pkg::ACC_BU, base + k, '0, '0);
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s: %0d mismatches", test_num, name, test_errors);
        test_num++;
        test_errors = 0;
    endtask

    task automatic misaligned_set(input logic with_regs);
        run_access(1'b0, mem_stage_pkg::ACC_W, 32'h301, '0, '0);
        if (with_regs)
            check_regs();
        run_access(1'b1, mem_stage_pkg::ACC_W, 32'h302, 32'hffee_ddcc, '0);
        if (with_regs)
            check_regs();
        run_access(1'b0, mem_stage_pkg::ACC_H, 32'h303, '0, '0);
        if (with_regs)
            check_regs();
        run_access(1'b1, mem_stage_pkg::ACC_HU, 32'h301, 32'h0000_8e71, '0);
        if (with_regs)
            check_regs();
        run_access(1'b0, mem_stage_pkg::ACC_W, 32'h300, '0, '0); // Shows what got written
    endtask

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    initial
    begin
        reset        = 1'b1;
        req          = '0;
        cfg          = '0;
        seed         = 32'hd0cac6cf;
        ref_mem      = '{default: '0};
        check_en_m   = 1'b1;
        last_code_m  = '0;
        bad_vaddr_m  = '0;
        exc_pc_m     = '0;
        exc_count_m  = '0;
        fault_total  = '0;
        pc_next      = 32'h0040_0000;
        test_num     = 1;
        test_errors  = 0;
        total_checks = 0;
        total_errors = 0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        run_access(1'b0, mem_stage_pkg::ACC_W, 32'h0000_0000, '0, '0);
        run_access(1'b0, mem_stage_pkg::ACC_W, 32'h0000_07fc, '0, '0);
        run_access(1'b0, mem_stage_pkg::ACC_W, 32'h1234_5ff8, '0, '0);
        run_access(1'b0, mem_stage_pkg::ACC_W, 32'hffff_fffc, '0, '0);
        run_access(1'b0, mem_stage_pkg::ACC_BU, 32'h0000_0a03, '0, '0);
        check_regs();
        end_test("reset state");

        run_access(1'b1, mem_stage_pkg::ACC_W, 32'h100, 32'h80f1_7e92, '0);
        run_access(1'b1, mem_stage_pkg::ACC_H, 32'h104, 32'h1111_9abc, '0);
        run_access(1'b1, mem_stage_pkg::ACC_HU, 32'h106, 32'h2222_7f01, '0);
        for (int k = 0; k < 4; k++)
            run_access(1'b1, k[0] ? mem_stage_pkg::ACC_BU : mem_stage_pkg::ACC_B,
                       32'h108 + k, $random(seed), '0);
        check_all_loads(32'h100);
        check_all_loads(32'h104);
        check_all_loads(32'h108);
        end_test("stores and extension");

        for (int b = 0; b < 4; b++)
        begin
            run_access(1'b1, mem_stage_pkg::ACC_W, 32'h200 + 8 * b, 32'h1122_3344, '0);
            run_access(1'b1, mem_stage_pkg::ACC_W, 32'h204 + 8 * b, 32'h1122_3344, '0);
            run_access(1'b1, mem_stage_pkg::ACC_WL, 32'h200 + 9 * b, 32'ha1b2_c3d4, '0);
            run_access(1'b1, mem_stage_pkg::ACC_WR, 32'h204 + 9 * b, 32'ha1b2_c3d4, '0);
            run_access(1'b0, mem_stage_pkg::ACC_W, 32'h200 + 8 * b, '0, '0);
            run_access(1'b0, mem_stage_pkg::ACC_W, 32'h204 + 8 * b, '0, '0);
            run_access(1'b0, mem_stage_pkg::ACC_WL, 32'h200 + 9 * b, '0, 32'h5566_7788);
            run_access(1'b0, mem_stage_pkg::ACC_WR, 32'h200 + 9 * b, '0, 32'h5566_7788);
            run_access(1'b0, mem_stage_pkg::ACC_WL, 32'h204 + 9 * b, '0, 32'h5566_7788);
            run_access(1'b0, mem_stage_pkg::ACC_WR, 32'h204 + 9 * b, '0, 32'h5566_7788);
        end
        end_test("unaligned merges");

        run_access(1'b1, mem_stage_pkg::ACC_W, 32'h300, 32'h0102_0304, '0);
        misaligned_set(1'b1);
        write_cfg(2'd3, '0);
        read_cfg(2'd3, exc_count_m, "exc_count");
        end_test("address errors");

        write_cfg(2'd0, '0);
        read_cfg(2'd0, {25'd0, last_code_m, 1'b0, check_en_m}, "control");
        misaligned_set(1'b0);
        read_cfg(2'd3, exc_count_m, "exc_count");
        write_cfg(2'd0, 32'd1);
        end_test("checking disabled");

        write_cfg(2'd3, '0);
        rand_start = fault_total;
        for (int n = 0; n < 300; n++)
        begin
            r_ctl  = $random(seed);
            r_addr = $random(seed);
            pick   = r_ctl[2:0];
            if (pick == 3'b001)
                pick = 3'b000; // Unused encoding
            run_access(r_ctl[3], mem_stage_pkg::mem_access_e'(pick),
                       {r_addr[31:12], 6'd0, r_addr[5:0]}, $random(seed), $random(seed));
        end
        read_cfg(2'd3, fault_total - rand_start, "exc_count");
        check_regs();
        end_test("random accesses");

        $display("Checks %0d, mismatches %0d", total_checks, total_errors);
        if (total_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- rtl/mem_stage.sv
`timescale 1ns/1ps

module mem_stage
(
    input  logic                    clk,
    input  logic                    reset,
    input  mem_stage_pkg::mem_req_t req,
    output mem_stage_pkg::mem_rsp_t rsp,
    input  mem_stage_pkg::cfg_req_t cfg,
    output logic [31:0]             cfg_rdata
);
    logic                     check_en;
    logic                     exc;
    mem_stage_pkg::exc_code_e exc_code;
    logic                     ram_we;
    logic [1:0]               eff_offset;
    logic [31:0]              rd_word;
    logic [31:0]              load_data;

    mem_align_check align_check_i
    (
        .req        (req),
        .check_en   (check_en),
        .exc        (exc),
        .exc_code   (exc_code),
        .ram_we     (ram_we),
        .eff_offset (eff_offset)
    );

    mem_exc_regs exc_regs_i
    (
        .clk       (clk),
        .reset     (reset),
        .cfg       (cfg),
        .cfg_rdata (cfg_rdata),
        .check_en  (check_en),
        .exc       (exc),
        .exc_code  (exc_code),
        .addr      (req.addr),
        .pc        (req.pc)
    );

    data_ram data_ram_i
    (
        .clk        (clk),
        .reset      (reset),
        .addr       (req.addr),
        .access     (req.access),
        .eff_offset (eff_offset),
        .wdata      (req.wdata),
        .we         (ram_we),
        .rd_word    (rd_word)
    );

    load_extend load_extend_i
    (
        .rd_word    (rd_word),
        .access     (req.access),
        .eff_offset (eff_offset),
        .rt_old     (req.rt_old),
        .rdata      (load_data)
    );

    assign rsp.rdata    = load_data;
    assign rsp.exc      = exc;
    assign rsp.exc_code = exc_code;

endmodule

//--- rtl/load_extend.sv
`timescale 1ns/1ps

module load_extend
(
    input  logic [31:0]                rd_word,
    input  mem_stage_pkg::mem_access_e access,
    input  logic [1:0]                 eff_offset,
    input  logic [31:0]                rt_old,
    output logic [31:0]                rdata
);
    logic [4:0]  lo_shift;
    logic [4:0]  hi_shift;
    logic [31:0] lane;
    logic [31:0] wl_mask;
    logic [31:0] wr_mask;

    assign lo_shift = {eff_offset, 3'b000};
    assign hi_shift = {~eff_offset, 3'b000};

    // Addressed byte or half moved down to bit 0
    assign lane = rd_word >> lo_shift;

    // Bits taken from memory for each merge
    assign wl_mask = 32'hffff_ffff << hi_shift;
    assign wr_mask = 32'hffff_ffff >> lo_shift;

    always_comb
    begin
        case (access)
            mem_stage_pkg::ACC_H:
                rdata = {{16{lane[15]}}, lane[15:0]};
            mem_stage_pkg::ACC_HU:
                rdata = {16'd0, lane[15:0]};
            mem_stage_pkg::ACC_B:
                rdata = {{24{lane[7]}}, lane[7:0]};
            mem_stage_pkg::ACC_BU:
                rdata = {24'd0, lane[7:0]};
            mem_stage_pkg::ACC_WL:
                rdata = (rd_word << hi_shift) | (rt_old & ~wl_mask); // Keep low rt bytes
            mem_stage_pkg::ACC_WR:
                rdata = (rd_word >> lo_shift) | (rt_old & ~wr_mask);
            default:
                rdata = rd_word;
        endcase
    end

endmodule

//--- rtl/data_ram.sv
`timescale 1ns/1ps
`include "mem_stage_cfg.svh"

module data_ram
(
    input  logic                       clk,
    input  logic                       reset,
    input  logic [31:0]                addr,
    input  mem_stage_pkg::mem_access_e access,
    input  logic [1:0]                 eff_offset,
    input  logic [31:0]                wdata,
    input  logic                       we,
    output logic [31:0]                rd_word
);
    logic [31:0]                  mem [`MEM_WORDS];
    logic [`MEM_INDEX_BITS-1:0]   word_idx;
    logic [4:0]                   lo_shift;
    logic [4:0]                   hi_shift;
    logic [31:0]                  lane_mask;
    logic [31:0]                  lane_data;

    assign word_idx = addr[`MEM_ADDR_BITS-1:2]; // Upper address bits wrap
    assign rd_word  = mem[word_idx];

    // 8*b and 8*(3-b)
    assign lo_shift = {eff_offset, 3'b000};
    assign hi_shift = {~eff_offset, 3'b000};

    always_comb
    begin
        case (access)
            mem_stage_pkg::ACC_W:
            begin
                lane_mask = 32'hffff_ffff;
                lane_data = wdata;
            end
            mem_stage_pkg::ACC_H,
            mem_stage_pkg::ACC_HU:
            begin
                lane_mask = 32'h0000_ffff << lo_shift;
                lane_data = wdata << lo_shift;
            end
            mem_stage_pkg::ACC_B,
            mem_stage_pkg::ACC_BU:
            begin
                lane_mask = 32'h0000_00ff << lo_shift;
                lane_data = wdata << lo_shift;
            end
            mem_stage_pkg::ACC_WL:
            begin
                // Upper wdata bytes land in bytes 0..b
                lane_mask = 32'hffff_ffff >> hi_shift;
                lane_data = wdata >> hi_shift;
            end
            mem_stage_pkg::ACC_WR:
            begin
                // Lower wdata bytes land in bytes b..3
                lane_mask = 32'hffff_ffff << lo_shift;
                lane_data = wdata << lo_shift;
            end
            default:
            begin
                lane_mask = '0;
                lane_data = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `MEM_WORDS; i++)
                mem[i] <= '0;
        end
        else if (we)
        begin
            mem[word_idx] <= (rd_word & ~lane_mask) | (lane_data & lane_mask);
        end
    end

endmodule

//--- rtl/mem_exc_regs.sv
`timescale 1ns/1ps

module mem_exc_regs
(
    input  logic                     clk,
    input  logic                     reset,
    input  mem_stage_pkg::cfg_req_t  cfg,
    output logic [31:0]              cfg_rdata,
    output logic                     check_en,
    input  logic                     exc,
    input  mem_stage_pkg::exc_code_e exc_code,
    input  logic [31:0]              addr,
    input  logic [31:0]              pc
);
    mem_stage_pkg::exc_code_e last_code; // Cause style field, control bits 6:2
    logic [31:0]              bad_vaddr;
    logic [31:0]              exc_pc;
    logic [31:0]              exc_count;
    logic                     count_clear;

    assign count_clear = cfg.we && (cfg.addr == 2'd3);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            check_en  <= 1'b1;
            last_code <= mem_stage_pkg::EXC_NONE;
            bad_vaddr <= '0;
            exc_pc    <= '0;
            exc_count <= '0;
        end
        else
        begin
            if (cfg.we && (cfg.addr == 2'd0))
                check_en <= cfg.wdata[0];

            if (exc)
            begin
                last_code <= exc_code;
                bad_vaddr <= addr;
                exc_pc    <= pc;
            end

            // Clear wins over a same-cycle fault
            if (count_clear)
                exc_count <= '0;
            else if (exc && (exc_count != '1))
                exc_count <= exc_count + 32'd1;
        end
    end

    always_comb
    begin
        case (cfg.addr)
            2'd0:    cfg_rdata = {25'd0, last_code, 1'b0, check_en};
            2'd1:    cfg_rdata = bad_vaddr;
            2'd2:    cfg_rdata = exc_pc;
            default: cfg_rdata = exc_count;
        endcase
    end

endmodule

//--- rtl/mem_align_check.sv
`timescale 1ns/1ps

module mem_align_check
(
    input  mem_stage_pkg::mem_req_t  req,
    input  logic                     check_en,
    output logic                     exc,
    output mem_stage_pkg::exc_code_e exc_code,
    output logic                     ram_we,
    output logic [1:0]               eff_offset
);
    logic [1:0] offset;
    logic       is_word;
    logic       is_half;
    logic       misaligned;

    assign offset  = req.addr[1:0];
    assign is_word = (req.access == mem_stage_pkg::ACC_W);
    assign is_half = (req.access == mem_stage_pkg::ACC_H) ||
                     (req.access == mem_stage_pkg::ACC_HU);

    // Bytes and the unaligned merges never fault
    assign misaligned = (is_word && (offset != 2'b00)) || (is_half && offset[0]);

    assign exc = req.valid && check_en && misaligned;

    always_comb
    begin
        if (!exc)
            exc_code = mem_stage_pkg::EXC_NONE;
        else if (req.we)
            exc_code = mem_stage_pkg::EXC_ADES;
        else
            exc_code = mem_stage_pkg::EXC_ADEL;
    end

    assign ram_we = req.valid && req.we && !exc; // Faulting store is dropped

    // Offset both data paths use when checking is off
    always_comb
    begin
        if (is_word)
            eff_offset = 2'b00;
        else if (is_half)
            eff_offset = {offset[1], 1'b0};
        else
            eff_offset = offset;
    end

endmodule

//--- rtl/mem_stage_pkg.sv
`include "mem_stage_cfg.svh"

package mem_stage_pkg;

    // Access kind, encoding follows the decode stage
    typedef enum logic [2:0]
    {
        ACC_W  = 3'b000,
        ACC_H  = 3'b010,
        ACC_HU = 3'b011,
        ACC_B  = 3'b100,
        ACC_BU = 3'b101,
        ACC_WL = 3'b110,
        ACC_WR = 3'b111
    } mem_access_e;

    typedef enum logic [4:0]
    {
        EXC_NONE = 5'd0,
        EXC_ADEL = `EXC_ADEL,
        EXC_ADES = `EXC_ADES
    } exc_code_e;

    typedef struct packed
    {
        logic        valid;
        logic        we;
        mem_access_e access;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] rt_old; // Old rt value for LWL/LWR
        logic [31:0] pc;
    } mem_req_t;

    typedef struct packed
    {
        logic [31:0] rdata;
        logic        exc;
        exc_code_e   exc_code;
    } mem_rsp_t;

    typedef struct packed
    {
        logic        we;
        logic [1:0]  addr;
        logic [31:0] wdata;
    } cfg_req_t;

endpackage

//--- include/mem_stage_cfg.svh
`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Byte address bits decoded by the data RAM, upper bits wrap
`define MEM_ADDR_BITS 12

// Word index width and RAM depth
`define MEM_INDEX_BITS (`MEM_ADDR_BITS - 2)
`define MEM_WORDS (1 << `MEM_INDEX_BITS)

// MIPS cause codes for address errors
`define EXC_ADEL 5'd4 // load or fetch
`define EXC_ADES 5'd5 // store

`endif
